/* source/fxp_pkg.sv */
/*
 * Fixed-point format for the vertex transform unit
 * Word width defaults and the accumulator rescale rule
 */

package fxp_pkg;

    // Q10.8 by default
    localparam int FXP_DATAWIDTH = 18;
    localparam int FXP_FRACBITS  = 8;

    // Widest word the rescale helper can return
    localparam int FXP_MAX_WIDTH = 32;

    // Keeps the accumulator sign and the DATAWIDTH-1 bits from FRACBITS up.
    // Plain truncation toward minus infinity, no rounding and no saturation.
    // Bits above the word are sign filled so callers may slice or cast down.
    function automatic logic signed [FXP_MAX_WIDTH-1:0] fxp_rescale(
        input logic signed [63:0] acc,
        input int                 datawidth,
        input int                 fracbits
    );
        logic signed [FXP_MAX_WIDTH-1:0] res;

        res = '0;
        for (int k = 0; k < FXP_MAX_WIDTH; k++) begin
            if (k < datawidth - 1) begin
                res[k] = acc[fracbits + k];
            end else begin
                res[k] = acc[63];
            end
        end
        return res;
    endfunction

endpackage

/* source/xform_pkg.sv */
/*
 * Transform unit dimensions and state encodings
 */

package xform_pkg;

    // Homogeneous coordinates
    localparam int DIM = 4;

    typedef logic [1:0] idx_t;

    // Multiplier FSM, shared by the matrix and vector multipliers
    typedef enum logic [1:0] {
        MM_IDLE = 2'b00,
        MM_PROC = 2'b01,
        MM_DONE = 2'b10
    } mm_state_t;

    // Sequencer FSM
    typedef enum logic [1:0] {
        SEQ_EMPTY   = 2'b00,
        SEQ_COMPOSE = 2'b01,
        SEQ_READY   = 2'b10
    } seq_state_t;

endpackage

/* source/mat_mul.sv */
/*
 * Sequential 4x4 by 4x4 fixed-point matrix multiplier
 * One inner index per cycle into sixteen wide accumulators
 */

`timescale 1ns/1ps

module mat_mul
    import fxp_pkg::*, xform_pkg::*;
#(
    parameter int DATAWIDTH = FXP_DATAWIDTH,
    parameter int FRACBITS  = FXP_FRACBITS
) (
    input  logic                        clk,
    input  logic                        rstn,

    input  logic signed [DATAWIDTH-1:0] i_a [DIM][DIM],
    input  logic signed [DATAWIDTH-1:0] i_b [DIM][DIM],
    input  logic                        i_dv,

    output logic signed [DATAWIDTH-1:0] o_c [DIM][DIM],
    output logic                        o_dv,
    output logic                        o_ready
);

    // Double width plus one guard bit
    localparam int ACCW = 2 * DATAWIDTH + 1;

    mm_state_t state;
    mm_state_t state_nxt;
    idx_t      idx;
    logic [1:0] start_sr;
    logic      accept;

    logic signed [DATAWIDTH-1:0] a_q [DIM][DIM];
    logic signed [DATAWIDTH-1:0] b_q [DIM][DIM];
    logic signed [ACCW-1:0]      acc [DIM][DIM];

    // Busy from the accept edge until the FSM is back in idle
    assign o_ready = (state == MM_IDLE) && (start_sr == 2'b00);
    assign accept  = i_dv && o_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= MM_IDLE;
            start_sr <= 2'b00;
            idx      <= '0;
            o_dv     <= 1'b0;
        end else begin
            state    <= state_nxt;
            start_sr <= {start_sr[0], accept};
            o_dv     <= (state == MM_DONE);
            if (accept) begin
                idx <= '0;
            end else if (state == MM_PROC) begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            MM_IDLE: begin
                // Two edges of operand settle after accept
                if (start_sr[1]) begin
                    state_nxt = MM_PROC;
                end
            end
            MM_PROC: begin
                if (idx == idx_t'(DIM - 1)) begin
                    state_nxt = MM_DONE;
                end
            end
            MM_DONE: begin
                state_nxt = MM_IDLE;
            end
            default: begin
                state_nxt = MM_IDLE;
            end
        endcase
    end

    // Operands and accumulators cleared per operation
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= i_a;
            b_q <= i_b;
            foreach (acc[r, c]) begin
                acc[r][c] <= '0;
            end
        end else if (state == MM_PROC) begin
            foreach (acc[r, c]) begin
                acc[r][c] <= acc[r][c] + a_q[r][idx] * b_q[idx][c];
            end
        end
    end

    // Result held until the next operation finishes
    always_ff @(posedge clk) begin
        if (state == MM_DONE) begin
            foreach (o_c[r, c]) begin
                o_c[r][c] <= DATAWIDTH'(fxp_rescale(acc[r][c], DATAWIDTH, FRACBITS));
            end
        end
    end

    // Strobe set on the seventh edge, so sampled high on the eighth
    a_fixed_latency : assert property (
        @(posedge clk) disable iff (!rstn)
        accept |-> ##8 o_dv
    ) else $error("mat_mul o_dv missing seven edges after accept");

endmodule

/* source/mat_vec_mul.sv */
/*
 * Sequential 4x4 matrix by 4-element vector multiplier
 * Walks one column per cycle into four wide accumulators
 */

`timescale 1ns/1ps

module mat_vec_mul
    import fxp_pkg::*, xform_pkg::*;
#(
    parameter int DATAWIDTH = FXP_DATAWIDTH,
    parameter int FRACBITS  = FXP_FRACBITS
) (
    input  logic                        clk,
    input  logic                        rstn,

    input  logic signed [DATAWIDTH-1:0] i_m [DIM][DIM],
    input  logic signed [DATAWIDTH-1:0] i_v [DIM],
    input  logic                        i_dv,

    output logic signed [DATAWIDTH-1:0] o_y [DIM],
    output logic                        o_dv,
    output logic                        o_ready
);

    localparam int ACCW = 2 * DATAWIDTH + 1;

    mm_state_t  state;
    mm_state_t  state_nxt;
    idx_t       idx;
    logic [1:0] start_sr;
    logic       accept;

    logic signed [DATAWIDTH-1:0] m_q [DIM][DIM];
    logic signed [DATAWIDTH-1:0] v_q [DIM];
    logic signed [ACCW-1:0]      acc [DIM];

    assign o_ready = (state == MM_IDLE) && (start_sr == 2'b00);
    assign accept  = i_dv && o_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= MM_IDLE;
            start_sr <= 2'b00;
            idx      <= '0;
            o_dv     <= 1'b0;
        end else begin
            state    <= state_nxt;
            start_sr <= {start_sr[0], accept};
            o_dv     <= (state == MM_DONE);
            if (accept) begin
                idx <= '0;
            end else if (state == MM_PROC) begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            MM_IDLE: if (start_sr[1]) state_nxt = MM_PROC;
            MM_PROC: if (idx == idx_t'(DIM - 1)) state_nxt = MM_DONE;
            MM_DONE: state_nxt = MM_IDLE;
            default: state_nxt = MM_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m_q <= i_m;
            v_q <= i_v;
            foreach (acc[r]) acc[r] <= '0;
        end else if (state == MM_PROC) begin
            // Column idx of the matrix against element idx of the vector
            foreach (acc[r]) acc[r] <= acc[r] + m_q[r][idx] * v_q[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (state == MM_DONE) begin
            foreach (o_y[r]) o_y[r] <= DATAWIDTH'(fxp_rescale(acc[r], DATAWIDTH, FRACBITS));
        end
    end

    // Upstream must hold off while busy, there is no input queue
    a_dv_respects_ready : assert property (
        @(posedge clk) disable iff (!rstn)
        i_dv |-> o_ready
    ) else $error("mat_vec_mul strobed while not ready");

endmodule

/* source/xform_seq.sv */
/*
 * Transform sequencer
 * Starts matrix composition, stores the product and admits vertices
 */

`timescale 1ns/1ps

module xform_seq
    import fxp_pkg::*, xform_pkg::*;
#(
    parameter int DATAWIDTH = FXP_DATAWIDTH
) (
    input  logic                        clk,
    input  logic                        rstn,

    // Host strobes
    input  logic                        i_mat_dv,
    input  logic                        i_vtx_dv,

    // Matrix multiplier side
    input  logic signed [DATAWIDTH-1:0] i_mm_c [DIM][DIM],
    input  logic                        i_mm_dv,
    input  logic                        i_mm_ready,
    output logic                        o_mm_dv,

    // Vector multiplier side
    input  logic                        i_mv_ready,
    output logic                        o_mv_dv,
    output logic signed [DATAWIDTH-1:0] o_mat [DIM][DIM],

    // Host status
    output logic                        o_mat_ready,
    output logic                        o_vtx_ready,
    output logic                        o_mat_done
);

    seq_state_t state;
    logic       mm_capture;

    // A new load may replace a finished transform but never interrupt a composition
    assign o_mat_ready = i_mm_ready && (state != SEQ_COMPOSE);
    assign o_mm_dv     = i_mat_dv && o_mat_ready;

    // Vertices only against a complete transform
    assign o_vtx_ready = i_mv_ready && (state == SEQ_READY);
    assign o_mv_dv     = i_vtx_dv && o_vtx_ready;

    assign mm_capture  = (state == SEQ_COMPOSE) && i_mm_dv;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= SEQ_EMPTY;
            o_mat_done <= 1'b0;
        end else begin
            o_mat_done <= mm_capture;
            case (state)
                SEQ_EMPTY, SEQ_READY: begin
                    if (o_mm_dv) begin
                        state <= SEQ_COMPOSE;
                    end
                end
                SEQ_COMPOSE: begin
                    if (i_mm_dv) begin
                        state <= SEQ_READY;
                    end
                end
                default: begin
                    state <= SEQ_EMPTY;
                end
            endcase
        end
    end

    // Current transform
    always_ff @(posedge clk) begin
        if (mm_capture) begin
            o_mat <= i_mm_c;
        end
    end

    // Products only arrive while a composition is pending
    a_mm_dv_in_compose : assert property (
        @(posedge clk) disable iff (!rstn)
        i_mm_dv |-> (state == SEQ_COMPOSE)
    ) else $error("matrix product arrived with no composition pending");

endmodule

/* source/xform_unit.sv */
/*
 * Fixed-point vertex transform unit
 * Composes view and model, then transforms a stream of vertices
 */

`timescale 1ns/1ps

module xform_unit
    import fxp_pkg::*, xform_pkg::*;
#(
    parameter int DATAWIDTH = FXP_DATAWIDTH,
    parameter int FRACBITS  = FXP_FRACBITS
) (
    input  logic                        clk,
    input  logic                        rstn,

    input  logic                        i_mat_dv,
    input  logic signed [DATAWIDTH-1:0] i_model [DIM][DIM],
    input  logic signed [DATAWIDTH-1:0] i_view  [DIM][DIM],
    input  logic                        i_vtx_dv,
    input  logic signed [DATAWIDTH-1:0] i_vtx   [DIM],

    output logic                        o_mat_ready,
    output logic                        o_vtx_ready,
    output logic                        o_mat_done,
    output logic                        o_vtx_dv,
    output logic signed [DATAWIDTH-1:0] o_vtx   [DIM]
);

    logic signed [DATAWIDTH-1:0] mm_c     [DIM][DIM];
    logic signed [DATAWIDTH-1:0] xform_m  [DIM][DIM];
    logic                        mm_start;
    logic                        mm_dv;
    logic                        mm_ready;
    logic                        mv_start;
    logic                        mv_ready;

    xform_seq #(
        .DATAWIDTH  (DATAWIDTH)
    ) seq_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_mat_dv    (i_mat_dv),
        .i_vtx_dv    (i_vtx_dv),
        .i_mm_c      (mm_c),
        .i_mm_dv     (mm_dv),
        .i_mm_ready  (mm_ready),
        .o_mm_dv     (mm_start),
        .i_mv_ready  (mv_ready),
        .o_mv_dv     (mv_start),
        .o_mat       (xform_m),
        .o_mat_ready (o_mat_ready),
        .o_vtx_ready (o_vtx_ready),
        .o_mat_done  (o_mat_done)
    );

    // View applied after model
    mat_mul #(
        .DATAWIDTH (DATAWIDTH),
        .FRACBITS  (FRACBITS)
    ) mm_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_a     (i_view),
        .i_b     (i_model),
        .i_dv    (mm_start),
        .o_c     (mm_c),
        .o_dv    (mm_dv),
        .o_ready (mm_ready)
    );

    mat_vec_mul #(
        .DATAWIDTH (DATAWIDTH),
        .FRACBITS  (FRACBITS)
    ) mv_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_m     (xform_m),
        .i_v     (i_vtx),
        .i_dv    (mv_start),
        .o_y     (o_vtx),
        .o_dv    (o_vtx_dv),
        .o_ready (mv_ready)
    );

endmodule

/* tb/tb_clk_gen.sv */
/*
 * Testbench clock and reset generator
 */

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rstn
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        o_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rstn = 1'b1;
    end

endmodule

/* tb/tb_xform_unit.sv */
/*
 * Vertex transform unit testbench
 * Table of matrix loads and vertices checked against an integer reference model
 */

`timescale 1ns/1ps

module tb_xform_unit
    import fxp_pkg::*, xform_pkg::*;
();

    localparam int W       = FXP_DATAWIDTH;
    localparam int F       = FXP_FRACBITS;
    localparam int ONE     = 1 << F;
    localparam int NROWS   = 36;
    localparam int TIMEOUT = NROWS * 12 + 50;
    localparam int K_EARLY = 0;
    localparam int K_LOAD  = 1;
    localparam int K_VTX   = 2;
    localparam int K_BURST = 3;

    logic                clk;
    logic                rstn;
    logic                i_mat_dv;
    logic                i_vtx_dv;
    logic signed [W-1:0] i_model [DIM][DIM];
    logic signed [W-1:0] i_view  [DIM][DIM];
    logic signed [W-1:0] i_vtx   [DIM];
    logic                o_mat_ready;
    logic                o_vtx_ready;
    logic                o_mat_done;
    logic                o_vtx_dv;
    logic signed [W-1:0] o_vtx   [DIM];

    // Stimulus table and expected results
    int                  row_kind  [NROWS];
    bit                  row_drop  [NROWS];
    logic signed [W-1:0] tbl_model [NROWS][DIM][DIM];
    logic signed [W-1:0] tbl_view  [NROWS][DIM][DIM];
    logic signed [W-1:0] tbl_vtx   [NROWS][DIM];
    logic [DIM*W-1:0]    tbl_exp   [NROWS];
    logic signed [W-1:0] ref_xf    [DIM][DIM];

    logic [DIM*W-1:0]    exp_q [$];
    logic [DIM*W-1:0]    got_exp;
    logic signed [W-1:0] exp_word;
    int                  errors = 0;
    int                  n_sent = 0;
    int                  n_recv = 0;
    int                  cycles = 0;

    tb_clk_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (2)
    ) clk_gen_i (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    xform_unit #(
        .DATAWIDTH (W),
        .FRACBITS  (F)
    ) dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_mat_dv    (i_mat_dv),
        .i_model     (i_model),
        .i_view      (i_view),
        .i_vtx_dv    (i_vtx_dv),
        .i_vtx       (i_vtx),
        .o_mat_ready (o_mat_ready),
        .o_vtx_ready (o_vtx_ready),
        .o_mat_done  (o_mat_done),
        .o_vtx_dv    (o_vtx_dv),
        .o_vtx       (o_vtx)
    );

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED @%0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        errors++;
    endtask

    // Sign of the full sum, then DATAWIDTH-1 bits from the binary point up
    function automatic logic signed [W-1:0] trunc_word(input longint acc);
        longint              shifted;
        logic signed [W-1:0] res;

        shifted = acc >>> F;
        res = shifted[W-1:0];
        res[W-1] = acc[63];
        return res;
    endfunction

    function automatic logic signed [W-1:0] rand_word(input int span);
        return W'(int'($urandom % span) - span / 2);
    endfunction

    // Transform is view times model
    task automatic ref_compose(input int i);
        longint sum;

        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                sum = 0;
                for (int k = 0; k < DIM; k++) begin
                    sum += longint'(tbl_view[i][r][k]) * longint'(tbl_model[i][k][c]);
                end
                ref_xf[r][c] = trunc_word(sum);
            end
        end
    endtask

    task automatic ref_transform(input int i);
        longint sum;

        for (int r = 0; r < DIM; r++) begin
            sum = 0;
            for (int k = 0; k < DIM; k++) begin
                sum += longint'(ref_xf[r][k]) * longint'(tbl_vtx[i][k]);
            end
            tbl_exp[i][r*W +: W] = trunc_word(sum);
        end
    endtask

    task automatic build_table();
        int kind;

        for (int i = 0; i < NROWS; i++) begin
            if (i == 0) begin
                kind = K_EARLY;
            end else if (i == 1 || i == 4 || i == 9 || i == 33) begin
                kind = K_LOAD;
            end else if (i >= 13 && i < 33) begin
                kind = K_BURST;
            end else begin
                kind = K_VTX;
            end
            row_kind[i] = kind;
            row_drop[i] = (i == 4 || i == 33);
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM; c++) begin
                    if (i == 1) begin
                        tbl_model[i][r][c] = (r == c) ? W'(ONE) : '0;
                        tbl_view[i][r][c]  = (r == c) ? W'(ONE) : '0;
                    end else begin
                        tbl_model[i][r][c] = rand_word(640);
                        tbl_view[i][r][c]  = rand_word(640);
                    end
                end
                tbl_vtx[i][r] = rand_word(2048);
            end
            if (kind == K_LOAD) begin
                ref_compose(i);
            end else if (kind != K_EARLY) begin
                ref_transform(i);
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic set_vertex(input int i);
        for (int r = 0; r < DIM; r++) begin
            i_vtx[r] = tbl_vtx[i][r];
        end
    endtask

    task automatic apply_early(input int i);
        set_vertex(i);
        i_vtx_dv = 1'b1;
        if (o_vtx_ready) begin
            report_mismatch("o_vtx_ready = 1 before any load, expected 0");
        end
        next_cycle();
        i_vtx_dv = 1'b0;
        repeat (10) next_cycle();
    endtask

    task automatic apply_load(input int i);
        while (!o_mat_ready || exp_q.size() != 0) begin
            @(negedge clk);
        end
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                i_model[r][c] = tbl_model[i][r][c];
                i_view[r][c]  = tbl_view[i][r][c];
            end
        end
        i_mat_dv = 1'b1;
        next_cycle();
        i_mat_dv = 1'b0;
        for (int k = 1; k <= 8; k++) begin
            // Vertex strobed mid composition must vanish
            if (k == 3 && row_drop[i]) begin
                set_vertex(i);
                i_vtx_dv = 1'b1;
            end
            next_cycle();
            i_vtx_dv = 1'b0;
            if (k < 8 && o_mat_done) begin
                report_error("o_mat_done came before the eighth edge after load accept");
            end
            if (k == 8 && !o_mat_done) begin
                report_error("o_mat_done missing eight edges after load accept");
            end
            if (k < 8 && (o_mat_ready || o_vtx_ready)) begin
                report_mismatch($sformatf("mat_ready %0b vtx_ready %0b during composition",
                                          o_mat_ready, o_vtx_ready));
            end
        end
    endtask

    task automatic apply_vertex(input int i);
        while (!o_vtx_ready) begin
            @(negedge clk);
        end
        set_vertex(i);
        i_vtx_dv = 1'b1;
        exp_q.push_back(tbl_exp[i]);
        n_sent++;
        next_cycle();
        i_vtx_dv = 1'b0;
        for (int k = 1; k <= 7; k++) begin
            next_cycle();
            if (k < 7 && o_vtx_dv) begin
                report_error("o_vtx_dv came before the seventh edge after vertex accept");
            end
            if (k == 7 && !o_vtx_dv) begin
                report_error("o_vtx_dv missing seven edges after vertex accept");
            end
        end
    endtask

    // Strobed every cycle and taken only on a ready cycle
    task automatic apply_burst(input int i);
        set_vertex(i);
        i_vtx_dv = 1'b1;
        if (o_vtx_ready) begin
            exp_q.push_back(tbl_exp[i]);
            n_sent++;
        end
        next_cycle();
        i_vtx_dv = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rstn && o_vtx_dv) begin
            if (exp_q.size() == 0) begin
                report_error("o_vtx_dv pulsed with no accepted vertex outstanding");
            end else begin
                got_exp = exp_q.pop_front();
                n_recv++;
                for (int r = 0; r < DIM; r++) begin
                    exp_word = got_exp[r*W +: W];
                    if (o_vtx[r] !== exp_word) begin
                        report_mismatch($sformatf("o_vtx[%0d] = %0d, expected %0d",
                                                  r, o_vtx[r], exp_word));
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        i_mat_dv = 1'b0;
        i_vtx_dv = 1'b0;
        for (int r = 0; r < DIM; r++) begin
            i_vtx[r] = '0;
            for (int c = 0; c < DIM; c++) begin
                i_model[r][c] = '0;
                i_view[r][c]  = '0;
            end
        end
        void'($urandom(20423));
        build_table();

        wait (rstn);
        @(negedge clk);
        if (o_vtx_dv !== 1'b0 || o_mat_done !== 1'b0 || o_mat_ready !== 1'b1
            || o_vtx_ready !== 1'b0) begin
            report_mismatch($sformatf(
                "after reset vtx_dv %0b mat_done %0b mat_ready %0b vtx_ready %0b",
                o_vtx_dv, o_mat_done, o_mat_ready, o_vtx_ready));
        end

        for (int i = 0; i < NROWS; i++) begin
            case (row_kind[i])
                K_EARLY: apply_early(i);
                K_LOAD:  apply_load(i);
                K_BURST: apply_burst(i);
                default: apply_vertex(i);
            endcase
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        next_cycle();

        $display("Vertices accepted %0d, results %0d, errors %0d", n_sent, n_recv, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* xform_unit.f */
source/fxp_pkg.sv
source/xform_pkg.sv
source/mat_mul.sv
source/mat_vec_mul.sv
source/xform_seq.sv
source/xform_unit.sv
tb/tb_clk_gen.sv
tb/tb_xform_unit.sv

/* Bender.yml */
package:
  name: xform_unit

sources:
  - source/fxp_pkg.sv
  - source/xform_pkg.sv
  - source/mat_mul.sv
  - source/mat_vec_mul.sv
  - source/xform_seq.sv
  - source/xform_unit.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_xform_unit.sv
